/* Makefile */
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 -f mt_fetch.f \
		--top-module tb_fetch_stage -Mdir obj_dir -o sim_fetch
	@out="$$(./obj_dir/sim_fetch)"; echo "$$out"; \
		echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir

/* credit_counter.sv */
`timescale 1ns/100ps

// Tracks the credits left on one link. A credit is spent when a request issues
// and comes back either from the far side or from a local release
module credit_counter import mt_fetch_pkg::*; #(
    parameter int MAX_CREDITS = IMEM_CREDITS       // Credits owned at reset
) (
    input  logic CLK,
    input  logic nRST,
    input  logic take,                             // One credit consumed this cycle
    input  logic give,                             // One credit returned by the far side
    input  logic release_res,                      // One reservation handed back locally
    output logic available
);

    logic [CREDIT_W-1:0] count;                    // Credits currently held
    logic [CREDIT_W-1:0] count_next;

    // All three events may land in one cycle
    // Modular sums are fine since the final count always stays in range
    always_comb begin
        count_next = count;
        if (give) begin
            count_next = count_next + CREDIT_W'(1);
        end
        if (release_res) begin
            count_next = count_next + CREDIT_W'(1);
        end
        if (take) begin
            count_next = count_next - CREDIT_W'(1);
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            count <= CREDIT_W'(MAX_CREDITS);       // Full pool after reset
        end else begin
            count <= count_next;
        end
    end

    // A request may issue only while at least one credit is held
    assign available = (count != '0);

endmodule

/* fetch_predecode.sv */
`timescale 1ns/100ps

// Next-PC guess from the instruction word alone. A JAL target needs only the
// PC and the immediate, so it is followed right away. Everything else falls
// through, and execute redirects if that was wrong
module fetch_predecode
    import mt_fetch_pkg::*;
    import rv32_isa_pkg::*;
(
    input  word_t instr,                           // Instruction returned by memory
    input  word_t pc,                              // Address it was fetched from
    output word_t npc
);

    opcode_t op;
    word_t   j_imm;                                // Sign-extended byte offset

    logic       imm_sign;
    logic [7:0] imm_19_12;
    logic       imm_11;
    logic [9:0] imm_10_1;

    assign op = opcode_t'(instr[OPCODE_MSB:OPCODE_LSB]);

    // ========================================
    // J-immediate reassembly
    // ========================================

    assign imm_sign  = instr[JIMM_SIGN_POS];
    assign imm_19_12 = instr[JIMM_19_12_MSB:JIMM_19_12_LSB];
    assign imm_11    = instr[JIMM_11_POS];
    assign imm_10_1  = instr[JIMM_10_1_MSB:JIMM_10_1_LSB];

    // Bit 0 is always zero, targets are at least halfword aligned
    assign j_imm = {{11{imm_sign}}, imm_sign, imm_19_12, imm_11, imm_10_1, 1'b0};

    // ========================================
    // Next PC
    // ========================================

    always_comb begin
        case (op)
            OP_JAL: begin
                npc = pc + j_imm;                  // Unconditional, always taken
            end
            default: begin
                // Branches predicted not taken, JALR left to execute
                npc = pc + 32'd4;
            end
        endcase
    end

endmodule

/* fetch_stage_top.sv */
`timescale 1ns/100ps

// Fetch front end for two interleaved harts. A request leaves only when a
// hart is idle and both the memory and execute links have credit. The
// response is predecoded, the hart's PC advances, and the instruction goes
// out to execute one cycle later unless a redirect squashed it
module fetch_stage_top import mt_fetch_pkg::*; (
    input  logic     CLK,
    input  logic     nRST,
    // Instruction memory
    output logic     imem_req,
    output word_t    imem_addr,
    output hart_id_t imem_req_hart,
    input  logic     imem_rsp,
    input  word_t    imem_rsp_data,
    input  hart_id_t imem_rsp_hart,
    input  logic     imem_credit,                  // Returned with every response
    // Execute
    output logic     fetch_valid,
    output word_t    fetch_pc,
    output word_t    fetch_instr,
    output hart_id_t fetch_hart,
    input  logic     exec_credit,                  // Execute freed one buffer slot
    input  logic     redirect,
    input  hart_id_t redirect_hart,
    input  word_t    redirect_pc
);

    logic                  issue;
    hart_id_t              issue_hart;
    logic                  issue_ok;
    logic                  imem_avail;
    logic                  exec_avail;
    logic [NUM_HARTS-1:0]  hart_idle;
    word_t [NUM_HARTS-1:0] pc;
    word_t                 rsp_pc;                 // PC of the hart whose response is back
    word_t                 npc;
    logic                  rsp_squashed;

    // ========================================
    // Issue side
    // ========================================

    // Execute slot is reserved up front so an output never waits for space
    assign issue_ok = imem_avail && exec_avail;

    hart_selector selector (
        .CLK        (CLK),
        .nRST       (nRST),
        .hart_idle  (hart_idle),
        .issue_ok   (issue_ok),
        .issue      (issue),
        .issue_hart (issue_hart)
    );

    assign imem_req      = issue;
    assign imem_addr     = pc[issue_hart];
    assign imem_req_hart = issue_hart;

    credit_counter #(.MAX_CREDITS(IMEM_CREDITS)) imem_credits (
        .CLK         (CLK),
        .nRST        (nRST),
        .take        (issue),
        .give        (imem_credit),
        .release_res (1'b0),                       // Memory always returns its own credits
        .available   (imem_avail)
    );

    // A squashed response gives its reserved slot straight back
    credit_counter #(.MAX_CREDITS(EXEC_CREDITS)) exec_credits (
        .CLK         (CLK),
        .nRST        (nRST),
        .take        (issue),
        .give        (exec_credit),
        .release_res (imem_rsp && rsp_squashed),
        .available   (exec_avail)
    );

    // ========================================
    // Response side
    // ========================================

    // PC still holds the fetch address, it moves only at the response edge
    assign rsp_pc = pc[imem_rsp_hart];

    fetch_predecode predecode (
        .instr (imem_rsp_data),
        .pc    (rsp_pc),
        .npc   (npc)
    );

    program_counter pc_unit (
        .CLK           (CLK),
        .nRST          (nRST),
        .issue         (issue),
        .issue_hart    (issue_hart),
        .rsp           (imem_rsp),
        .rsp_hart      (imem_rsp_hart),
        .npc           (npc),
        .redirect      (redirect),
        .redirect_hart (redirect_hart),
        .redirect_pc   (redirect_pc),
        .pc            (pc),
        .hart_idle     (hart_idle),
        .rsp_squashed  (rsp_squashed)
    );

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            fetch_valid <= 1'b0;
        end else begin
            fetch_valid <= imem_rsp && !rsp_squashed;  // Wrong-path fetches never show
        end
    end

    // Output fields only mean something while fetch_valid is high
    always_ff @(posedge CLK) begin
        if (imem_rsp) begin
            fetch_pc    <= rsp_pc;
            fetch_instr <= imem_rsp_data;
            fetch_hart  <= imem_rsp_hart;
        end
    end

endmodule

/* hart_selector.sv */
`timescale 1ns/100ps

// Round-robin pick of the next hart to fetch. Only harts with no fetch in
// flight compete, and a grant happens only when both links have credit
module hart_selector import mt_fetch_pkg::*; (
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic [NUM_HARTS-1:0] hart_idle,        // One bit per hart, high when nothing in flight
    input  logic                 issue_ok,         // Both credit pools can take a request
    output logic                 issue,
    output hart_id_t             issue_hart
);

    hart_id_t last_hart;                           // Most recently granted hart
    hart_id_t cand;                                // Hart examined in the current loop step
    hart_id_t pick;
    logic     found;

    // ========================================
    // Search order starts just after the last grant
    // ========================================

    always_comb begin
        found = 1'b0;
        pick  = last_hart;
        cand  = last_hart;
        for (int k = 1; k <= NUM_HARTS; k++) begin
            cand = hart_id_t'((int'(last_hart) + k) % NUM_HARTS);
            if (!found && hart_idle[cand]) begin
                found = 1'b1;                      // First idle hart in rotation wins
                pick  = cand;
            end
        end
    end

    // Nothing is granted while reset is held
    assign issue      = nRST && found && issue_ok;
    assign issue_hart = pick;

    // ========================================
    // Pointer update
    // ========================================

    // The pointer only moves on a real grant, so a stalled cycle does not
    // rob a hart of its turn
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            last_hart <= hart_id_t'(NUM_HARTS - 1);    // Hart 0 gets the first grant
        end else if (issue) begin
            last_hart <= pick;
        end
    end

endmodule

/* mt_fetch.f */
mt_fetch_pkg.sv
rv32_isa_pkg.sv
credit_counter.sv
hart_selector.sv
program_counter.sv
fetch_predecode.sv
fetch_stage_top.sv
tb_fetch_memory.sv
tb_fetch_stage.sv

/* mt_fetch_pkg.sv */
// ========================================
// Threading parameters
// ========================================

package mt_fetch_pkg;

    localparam int NUM_HARTS = 2;                  // Hardware threads sharing the front end
    localparam int HART_ID_W = 1;                  // Bits needed to name one hart

    // Identifies the hart that owns a request, response or output
    typedef logic [HART_ID_W-1:0] hart_id_t;

    // Addresses and instruction words share one width on RV32
    typedef logic [31:0] word_t;

    // Hart 0 starts here, each further hart sits one stride higher
    localparam word_t RESET_PC       = 32'h8000_0000;
    localparam word_t HART_PC_STRIDE = 32'd12;     // Byte offset between reset PCs

    // ========================================
    // Flow control
    // ========================================

    // Requests the instruction memory can accept before it must return a credit
    localparam int IMEM_CREDITS = 2;

    // Buffer slots on the execute side, one per fetched instruction held there
    localparam int EXEC_CREDITS = 2;

    // Wide enough for the larger of the two credit pools
    localparam int CREDIT_W = 2;

endpackage

/* program_counter.sv */
`timescale 1ns/100ps

// Per-hart fetch state. Each hart owns a PC, a flag for its one fetch in
// flight, and a flag that marks that fetch as wrong path after a redirect
module program_counter import mt_fetch_pkg::*; (
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic                 issue,            // Request sent this cycle
    input  hart_id_t             issue_hart,
    input  logic                 rsp,              // Memory response this cycle
    input  hart_id_t             rsp_hart,
    input  word_t                npc,              // Predicted next PC for the responding hart
    input  logic                 redirect,         // Execute corrects a hart's path
    input  hart_id_t             redirect_hart,
    input  word_t                redirect_pc,
    output word_t [NUM_HARTS-1:0] pc,
    output logic [NUM_HARTS-1:0] hart_idle,
    output logic                 rsp_squashed      // Current response must not reach execute
);

    logic [NUM_HARTS-1:0] outstanding;             // A fetch is in flight for this hart
    logic [NUM_HARTS-1:0] squashed;                // That fetch belongs to an old path

    // ========================================
    // Response filtering
    // ========================================

    // A redirect in the same cycle as the response also kills it, since that
    // fetch was still in flight when execute changed the path
    assign rsp_squashed = rsp &&
                          (squashed[rsp_hart] || (redirect && (redirect_hart == rsp_hart)));

    assign hart_idle = ~outstanding;               // Idle harts may be picked for issue

    // ========================================
    // Per-hart state
    // ========================================

    for (genvar h = 0; h < NUM_HARTS; h++) begin : g_hart
        logic issue_here;
        logic rsp_here;
        logic redir_here;

        assign issue_here = issue && (issue_hart == hart_id_t'(h));
        assign rsp_here   = rsp && (rsp_hart == hart_id_t'(h));
        assign redir_here = redirect && (redirect_hart == hart_id_t'(h));

        always_ff @(posedge CLK, negedge nRST) begin
            if (!nRST) begin
                pc[h]          <= RESET_PC + word_t'(h) * HART_PC_STRIDE;
                outstanding[h] <= 1'b0;
                squashed[h]    <= 1'b0;
            end else begin
                // Redirect has priority over the predicted PC
                if (redir_here) begin
                    pc[h] <= redirect_pc;
                end else if (rsp_here && !squashed[h]) begin
                    pc[h] <= npc;                  // Advance along the predicted path
                end

                // Issue and response never hit the same hart in one cycle
                if (issue_here) begin
                    outstanding[h] <= 1'b1;
                end else if (rsp_here) begin
                    outstanding[h] <= 1'b0;
                end

                // A fetch issued in the redirect cycle used the old PC, so it
                // is marked wrong path too
                if (rsp_here) begin
                    squashed[h] <= 1'b0;           // Response consumed, flag no longer needed
                end else if (redir_here && (outstanding[h] || issue_here)) begin
                    squashed[h] <= 1'b1;
                end
            end
        end
    end

endmodule

/* rv32_isa_pkg.sv */
package rv32_isa_pkg;

    // ========================================
    // Major opcodes
    // ========================================

    // Bits [6:0] of every 32-bit RV32 instruction
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,                    // Only this one changes the fetch path here
        OP_JALR   = 7'b1100111,                    // Target needs a register, left to execute
        OP_BRANCH = 7'b1100011,                    // Predicted not taken
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_OPIMM  = 7'b0010011,
        OP_OP     = 7'b0110011,
        OP_SYSTEM = 7'b1110011
    } opcode_t;

    // ========================================
    // Field positions
    // ========================================

    localparam int OPCODE_LSB = 0;
    localparam int OPCODE_MSB = 6;

    // The J-type immediate is scattered across the upper 20 bits
    localparam int JIMM_SIGN_POS   = 31;           // imm[20], also the sign bit
    localparam int JIMM_10_1_MSB   = 30;           // imm[10:1] upper end
    localparam int JIMM_10_1_LSB   = 21;
    localparam int JIMM_11_POS     = 20;           // imm[11]
    localparam int JIMM_19_12_MSB  = 19;           // imm[19:12] upper end
    localparam int JIMM_19_12_LSB  = 12;

endpackage

/* tb_fetch_memory.sv */
`timescale 1ns/100ps

// Instruction memory model for the fetch testbench. Each request waits in a
// slot with its own random delay, so a later request may answer first
module tb_fetch_memory import mt_fetch_pkg::*; (
    input  logic     CLK,
    input  logic     nRST,
    input  logic     req,
    input  word_t    addr,
    input  hart_id_t req_hart,
    output logic     rsp,
    output word_t    rsp_data,
    output hart_id_t rsp_hart,
    output logic     credit                        // Pulses with every response
);

    localparam int SLOTS = 4;                      // Room beyond the credit limit

    logic [SLOTS-1:0] busy;
    word_t            slot_addr [SLOTS];
    hart_id_t         slot_hart [SLOTS];
    int               slot_wait [SLOTS];           // Cycles left before the slot may answer
    integer           seed = 32'hc4a5_7858;
    logic             done;

    // JAL +16 where bit 5 is set, else an ADDI whose fields fold in the address
    function automatic word_t instr_at(word_t a);
        logic [16:0] fold;
        fold = a[18:2] ^ a[31:15];
        if (a[5]) begin
            return {12'h010, 8'h00, a[11:7], 7'h6f};
        end
        return {fold, 3'b000, 5'd1, 7'h13};
    endfunction

    initial begin
        rsp      = 1'b0;
        credit   = 1'b0;
        rsp_data = '0;
        rsp_hart = '0;
        busy     = '0;
        forever begin
            @(posedge CLK);
            #2;
            rsp    = 1'b0;
            credit = 1'b0;
            done   = 1'b0;
            if (!nRST) begin
                busy = '0;
            end else begin
                for (int k = 0; k < SLOTS; k++) begin
                    if (busy[k] && slot_wait[k] == 0 && !done) begin
                        rsp      = 1'b1;               // One answer per cycle on the port
                        credit   = 1'b1;
                        rsp_data = instr_at(slot_addr[k]);
                        rsp_hart = slot_hart[k];
                        busy[k]  = 1'b0;
                        done     = 1'b1;
                    end else if (busy[k] && slot_wait[k] > 0) begin
                        slot_wait[k]--;
                    end
                end
            end
            @(negedge CLK);                                // DUT outputs settled by now
            done = 1'b0;
            for (int k = 0; k < SLOTS; k++) begin
                if (nRST && req && !busy[k] && !done) begin
                    busy[k]      = 1'b1;
                    slot_addr[k] = addr;
                    slot_hart[k] = req_hart;
                    slot_wait[k] = int'($unsigned($random(seed)) % 32'd4);   // Latency 1 to 4
                    done         = 1'b1;
                end
            end
        end
    end

endmodule

/* tb_fetch_stage.sv */
`timescale 1ns/100ps

// Testbench for the two-hart fetch stage. A model of each hart's expected
// PC is updated at every falling edge from what the DUT and memory show
module tb_fetch_stage import mt_fetch_pkg::*; ();

    localparam int CLK_PERIOD = 20;
    localparam int WATCHDOG_CYCLES = 50 + 300 + 300 + 200 + 300 + 250;  // Test budgets and margin

    logic     CLK, nRST, imem_req, imem_rsp, imem_credit, fetch_valid;
    logic     exec_credit, redirect;
    word_t    imem_addr, imem_rsp_data, fetch_pc, fetch_instr, redirect_pc;
    hart_id_t imem_req_hart, imem_rsp_hart, fetch_hart, redirect_hart;

    word_t                exp_pc [NUM_HARTS];      // Next request address each hart must use
    word_t                req_pc [NUM_HARTS];      // Address of the fetch in flight
    logic [NUM_HARTS-1:0] inflight, squash_pending, seen_first, after_redirect;
    hart_id_t             last_hart, pend_hart;
    logic                 have_last, pend_valid, withhold, slow_credits;
    int imem_inflight, exec_reserved, exec_held, requests, outputs;
    int alt_checks, squashes, followed, errors, tests_failed, m0, target, tick;

    fetch_stage_top UUT (.*);
    tb_fetch_memory memory (.CLK(CLK), .nRST(nRST), .req(imem_req), .addr(imem_addr),
        .req_hart(imem_req_hart), .rsp(imem_rsp), .rsp_data(imem_rsp_data),
        .rsp_hart(imem_rsp_hart), .credit(imem_credit));

    always #(CLK_PERIOD / 2) CLK = ~CLK;

    function automatic word_t expected_word(word_t a);
        logic [16:0] fold;
        fold = a[18:2] ^ a[31:15];
        return a[5] ? {12'h010, 8'h00, a[11:7], 7'h6f} : {fold, 3'b000, 5'd1, 7'h13};
    endfunction

    task automatic report_mismatch(string msg);
        $display("FAIL %0t: %s", $time, msg);
        errors++;
    endtask

    // ========================================
    // Cycle checker
    // ========================================
    task automatic check_cycle();
        hart_id_t h;
        if (!nRST) begin
            assert (!imem_req && !fetch_valid) else report_mismatch("activity during reset");
            exp_pc[0] = 32'h8000_0000;             // Hart 0 reset PC
            exp_pc[1] = 32'h8000_000c;             // Hart 1 starts 12 bytes higher
            {inflight, squash_pending, after_redirect, have_last, pend_valid} = '0;
            {imem_inflight, exec_reserved, exec_held} = '0;
            return;
        end
        assert (fetch_valid == pend_valid) else report_mismatch("fetch_valid not one cycle after rsp");
        if (fetch_valid && pend_valid) begin
            h = fetch_hart;
            assert (h == pend_hart) else report_mismatch("fetch_hart differs from responding hart");
            assert (fetch_pc == req_pc[h]) else report_mismatch($sformatf("fetch_pc %h", fetch_pc));
            assert (fetch_instr == expected_word(req_pc[h])) else report_mismatch("wrong fetch_instr");
            exp_pc[h] = req_pc[h] + (req_pc[h][5] ? 32'd16 : 32'd4);  // JAL +16, ADDI +4
            outputs++;
            exec_held++;
        end
        if (exec_credit) begin
            exec_held--;
            exec_reserved--;
        end
        if (imem_req) begin
            h = imem_req_hart;
            assert (!inflight[h]) else report_mismatch("second fetch in flight for one hart");
            assert (imem_addr == exp_pc[h]) else report_mismatch(
                $sformatf("hart %0d fetched %h, expected %h", h, imem_addr, exp_pc[h]));
            if (inflight == '0 && have_last) begin
                assert (h != last_hart) else report_mismatch("round robin did not alternate");
                alt_checks++;
            end
            followed += int'(after_redirect[h]);   // First fetch on the new path
            {after_redirect[h], inflight[h], seen_first[h], have_last} = 4'b0111;
            req_pc[h] = imem_addr;
            last_hart = h;
            requests++;
            imem_inflight++;
            exec_reserved++;
        end
        pend_valid = 1'b0;
        if (imem_rsp) begin
            h = imem_rsp_hart;
            assert (inflight[h]) else report_mismatch("response with no fetch in flight");
            inflight[h] = 1'b0;
            if (squash_pending[h] || (redirect && redirect_hart == h)) begin
                squashes++;                        // Dropped, its execute slot comes back
                exec_reserved--;
                squash_pending[h] = 1'b0;
            end else begin
                pend_valid = 1'b1;
                pend_hart  = h;
            end
        end
        imem_inflight -= int'(imem_credit);
        if (redirect) begin
            exp_pc[redirect_hart]         = redirect_pc;
            after_redirect[redirect_hart] = 1'b1;
            squash_pending[redirect_hart] = inflight[redirect_hart];
        end
        assert (imem_inflight <= IMEM_CREDITS) else report_mismatch("imem credits exceeded");
        assert (exec_reserved <= EXEC_CREDITS) else report_mismatch("exec reservations exceeded");
        assert (exec_held <= EXEC_CREDITS) else report_mismatch("execute buffer overflow");
    endtask

    initial forever begin
        @(negedge CLK);
        check_cycle();
    end

    // Execute returns one credit every other cycle, or every sixth when slowed
    initial begin
        exec_credit = 1'b0;
        tick = 0;
        forever begin
            @(posedge CLK);
            #2;
            exec_credit = nRST && !withhold && exec_held > 0 && (tick % (slow_credits ? 6 : 2) == 0);
            tick++;
        end
    end

    task automatic send_redirect(hart_id_t h, word_t target_pc);
        do @(posedge CLK); while (!inflight[h]);
        #2;
        {redirect, redirect_hart, redirect_pc} = {1'b1, h, target_pc};
        @(posedge CLK);
        #2;
        redirect = 1'b0;
    endtask

    task automatic finish_test(string name, logic goal_met, string goal_msg);
        if (!goal_met) $display("%s: %s", name, goal_msg);
        if (!goal_met || errors != m0) tests_failed++;
        $display("Test %-16s %s, %0d mismatches", name,
                 (goal_met && errors == m0) ? "ok" : "FAILED", errors - m0);
        m0 = errors;
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Test failures found");
        $finish;
    end

    // ========================================
    // Test sequence
    // ========================================
    initial begin
        {CLK, nRST, redirect, redirect_hart, redirect_pc, withhold, slow_credits} = '0;
        {seen_first, requests, outputs, alt_checks, squashes, followed} = '0;
        {errors, tests_failed, m0} = '0;
        repeat (3) @(posedge CLK);
        #2 nRST = 1'b1;
        while (seen_first != '1) @(posedge CLK);
        finish_test("reset_pc", 1'b1, "");
        target = outputs + 40;
        while (outputs < target) @(posedge CLK);
        finish_test("predecode_path", 1'b1, "");
        @(negedge CLK) slow_credits = 1'b1;        // Starve execute so both harts sit idle
        target = alt_checks + 10;
        while (alt_checks < target) @(posedge CLK);
        @(negedge CLK) slow_credits = 1'b0;
        finish_test("round_robin", 1'b1, "");
        target = squashes + 2;
        send_redirect(1'b0, 32'h8000_0400);
        send_redirect(1'b1, 32'h8000_0524);
        while (followed < 2) @(posedge CLK);
        finish_test("redirect", squashes >= target, "a fetch in flight at a redirect was kept");
        @(negedge CLK) withhold = 1'b1;
        repeat (10) @(posedge CLK);
        target = requests;
        repeat (20) @(posedge CLK);
        target = (requests == target) ? outputs + 20 : -1;   // Stalled, so wait for 20 more
        @(negedge CLK) withhold = 1'b0;
        while (target > 0 && outputs < target) @(posedge CLK);
        finish_test("backpressure", target > 0, "issue went on while execute held its credits");
        $display("Summary: 5 tests, %0d failed, %0d mismatches", tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
